// ==== build.f ====
+incdir+test
src/mem_pkg.sv
src/dual_port_ram.sv
src/axi_bram_ctrl.sv
src/mem_subsystem.sv
test/mem_subsystem_tb.sv

// ==== Makefile ====
# Verilator build and run of the memory subsystem testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0
TOP       ?= mem_subsystem_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TEST OK" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/axi_master.svh ====
// included inside mem_subsystem_tb, port index 0 is imem and 1 is dmem, each wait times out
`ifndef AXI_MASTER_SVH
`define AXI_MASTER_SVH

localparam int TIMEOUT = 100;
localparam logic [31:0] SEED = 32'd34;

// only the upper bits of an LCG step are random enough
function automatic logic [31:0] lcg_step(input logic [31:0] st);
	return st * 32'd1664525 + 32'd1013904223;
endfunction

task automatic start_write(input int p, input mem_pkg::addr_t addr, input mem_pkg::word_t data,
		input mem_pkg::strb_t strb);
	aw[p].addr <= addr;
	w[p].data <= data;
	w[p].strb <= strb;
	awvalid[p] <= 1'b1;
	wvalid[p] <= 1'b1;
endtask

task automatic start_read(input int p, input mem_pkg::addr_t addr);
	ar[p].addr <= addr;
	arvalid[p] <= 1'b1;
endtask

task automatic wait_accept(input int p, input logic is_wr);
	int n;
	logic done;
	n = 0;
	do begin
		@(posedge clk);
		n++;
		if (n > TIMEOUT) begin
			$display("%s: %s request was never accepted", port_name(p),
				is_wr ? "write" : "read");
			abort_test();
		end
		done = is_wr ? (awready[p] && wready[p]) : arready[p];
	end while (!done);
	if (is_wr) begin
		awvalid[p] <= 1'b0;
		wvalid[p] <= 1'b0;
	end else begin
		arvalid[p] <= 1'b0;
	end
endtask

// ready held low for delay cycles
task automatic wait_response(input int p, input logic is_wr, input int delay);
	int n;
	logic done;
	n = 0;
	do begin
		if (n >= delay) begin
			if (is_wr) begin
				bready[p] <= 1'b1;
			end else begin
				rready[p] <= 1'b1;
			end
		end
		@(posedge clk);
		n++;
		if (n > TIMEOUT) begin
			$display("%s: %s response never arrived", port_name(p),
				is_wr ? "write" : "read");
			abort_test();
		end
		done = is_wr ? (bvalid[p] && bready[p]) : (rvalid[p] && rready[p]);
	end while (!done);
	bready[p] <= 1'b0;
	rready[p] <= 1'b0;
endtask

task automatic run_master(input int p, input int n_ops);
	logic [31:0] st;
	mem_pkg::addr_t addr;
	mem_pkg::word_t data;
	mem_pkg::strb_t strb;
	int delay;
	logic is_wr;
	int pend_delay;
	logic pend_wr;
	st = SEED + 32'(p);
	pend_delay = 0;
	pend_wr = 1'b0;
	for (int i = 0; i < n_ops; i++) begin
		st = lcg_step(st);
		if (st[31:29] == 3'd0) begin
			// MEM_BYTES is a power of two, so this lands past the end
			addr = st[15:0] | mem_pkg::MEM_BYTES;
		end else begin
			// 8-word window with random low address bits
			addr = mem_pkg::addr_t'(st[20:16]);
		end
		st = lcg_step(st);
		data = st;
		st = lcg_step(st);
		strb = st[27:24];
		delay = int'(st[29:28]);
		is_wr = st[31];
		if (is_wr) begin
			start_write(p, addr, data, strb);
		end else begin
			start_read(p, addr);
		end
		// next request is already valid while the previous response is pending
		if (i > 0) begin
			wait_response(p, pend_wr, pend_delay);
		end
		wait_accept(p, is_wr);
		pend_wr = is_wr;
		pend_delay = delay;
	end
	wait_response(p, pend_wr, pend_delay);
endtask

`endif

// ==== test/mem_subsystem_tb.sv ====
// two random AXI4-Lite masters on imem and dmem with in-range traffic inside an 8-word window
`default_nettype none
`timescale 1ns/100ps

module mem_subsystem_tb;

	localparam int N_OPS = 400;
	localparam int WIN_WORDS = 8;

	logic clk;
	logic rst;

	// index 0 is imem, index 1 is dmem
	mem_pkg::axi_aw_t aw [2];
	logic awvalid [2];
	logic awready [2];
	mem_pkg::axi_w_t w [2];
	logic wvalid [2];
	logic wready [2];
	mem_pkg::resp_t b_resp [2];
	logic bvalid [2];
	logic bready [2];
	mem_pkg::axi_ar_t ar [2];
	logic arvalid [2];
	logic arready [2];
	mem_pkg::axi_r_t r [2];
	logic rvalid [2];
	logic rready [2];

	// reference memory and per-port expectations
	mem_pkg::word_t model [mem_pkg::RAM_DEPTH];
	mem_pkg::axi_r_t exp_r [2];
	mem_pkg::resp_t exp_b [2];
	mem_pkg::axi_r_t r_q [2];
	mem_pkg::resp_t b_q [2];
	logic rvalid_q [2];
	logic bvalid_q [2];
	int ar_cycle [2];
	int aw_cycle [2];
	int cycle = 0;

	mem_subsystem dut_i (
		.clk(clk), .rst(rst),
		.imem_aw(aw[0]), .imem_awvalid(awvalid[0]), .imem_awready(awready[0]),
		.imem_w(w[0]), .imem_wvalid(wvalid[0]), .imem_wready(wready[0]),
		.imem_b_resp(b_resp[0]), .imem_bvalid(bvalid[0]), .imem_bready(bready[0]),
		.imem_ar(ar[0]), .imem_arvalid(arvalid[0]), .imem_arready(arready[0]),
		.imem_r(r[0]), .imem_rvalid(rvalid[0]), .imem_rready(rready[0]),
		.dmem_aw(aw[1]), .dmem_awvalid(awvalid[1]), .dmem_awready(awready[1]),
		.dmem_w(w[1]), .dmem_wvalid(wvalid[1]), .dmem_wready(wready[1]),
		.dmem_b_resp(b_resp[1]), .dmem_bvalid(bvalid[1]), .dmem_bready(bready[1]),
		.dmem_ar(ar[1]), .dmem_arvalid(arvalid[1]), .dmem_arready(arready[1]),
		.dmem_r(r[1]), .dmem_rvalid(rvalid[1]), .dmem_rready(rready[1])
	);

	function automatic string port_name(input int p);
		return (p == 0) ? "imem" : "dmem";
	endfunction

	task automatic abort_test();
		$display("TEST FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_resp(input string name, input mem_pkg::resp_t got,
			input mem_pkg::resp_t exp);
		if (got !== exp) begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			abort_test();
		end
	endtask

	task automatic check_rdata(input string name, input mem_pkg::axi_r_t got,
			input mem_pkg::axi_r_t exp);
		if (got !== exp) begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			abort_test();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			abort_test();
		end
	endtask

	task automatic check_latency(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("** Error: %s latency = %h, expected %h", name, got, exp);
			abort_test();
		end
	endtask

	`include "axi_master.svh"

	task automatic watch_responses(input int p);
		if (rvalid[p] && !rvalid_q[p]) begin
			check_latency({port_name(p), "_rvalid"}, cycle - ar_cycle[p], 2);
		end
		if (bvalid[p] && !bvalid_q[p]) begin
			check_latency({port_name(p), "_bvalid"}, cycle - aw_cycle[p], 1);
		end
		// payload must hold while valid waits for ready
		if (rvalid[p] && rvalid_q[p]) begin
			check_rdata({port_name(p), "_r"}, r[p], r_q[p]);
		end
		if (bvalid[p] && bvalid_q[p]) begin
			check_resp({port_name(p), "_b_resp"}, b_resp[p], b_q[p]);
		end
		if (rvalid[p] && rready[p]) begin
			check_rdata({port_name(p), "_r"}, r[p], exp_r[p]);
		end
		if (bvalid[p] && bready[p]) begin
			check_resp({port_name(p), "_b_resp"}, b_resp[p], exp_b[p]);
		end
		// awready and wready only ever rise together
		check_bit({port_name(p), "_wready"}, wready[p], awready[p]);
		if (bvalid[p] || rvalid[p]) begin
			check_bit({port_name(p), "_arready"}, arready[p], 1'b0);
			check_bit({port_name(p), "_awready"}, awready[p], 1'b0);
		end
		rvalid_q[p] = rvalid[p];
		bvalid_q[p] = bvalid[p];
		r_q[p] = r[p];
		b_q[p] = b_resp[p];
	endtask

	task automatic sample_read(input int p);
		if (arvalid[p] && arready[p]) begin
			ar_cycle[p] = cycle;
			if (ar[p].addr < mem_pkg::MEM_BYTES) begin
				exp_r[p].data = model[mem_pkg::ram_addr_t'(ar[p].addr >> 2)];
				exp_r[p].resp = mem_pkg::RESP_OKAY;
			end else begin
				exp_r[p].data = '0;
				exp_r[p].resp = mem_pkg::RESP_SLVERR;
			end
		end
	endtask

	task automatic record_write(input int p);
		mem_pkg::ram_addr_t wd;
		if (awvalid[p] && awready[p] && wvalid[p] && wready[p]) begin
			aw_cycle[p] = cycle;
			wd = mem_pkg::ram_addr_t'(aw[p].addr >> 2);
			if (aw[p].addr < mem_pkg::MEM_BYTES) begin
				exp_b[p] = mem_pkg::RESP_OKAY;
				for (int i = 0; i < mem_pkg::STRB_W; i++) begin
					if (w[p].strb[i]) begin
						model[wd][i*8 +: 8] = w[p].data[i*8 +: 8];
					end
				end
			end else begin
				exp_b[p] = mem_pkg::RESP_SLVERR;
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// reads see old data and the dmem write goes before the imem write so imem bytes win
	always @(posedge clk) begin
		cycle++;
		if (rst) begin
			for (int p = 0; p < 2; p++) begin
				rvalid_q[p] = 1'b0;
				bvalid_q[p] = 1'b0;
			end
		end else begin
			for (int p = 0; p < 2; p++) begin
				watch_responses(p);
			end
			for (int p = 0; p < 2; p++) begin
				sample_read(p);
			end
			record_write(1);
			record_write(0);
		end
	end

	initial begin
		logic [31:0] st;
		rst <= 1'b1;
		for (int p = 0; p < 2; p++) begin
			aw[p] <= '0;
			awvalid[p] <= 1'b0;
			w[p] <= '0;
			wvalid[p] <= 1'b0;
			bready[p] <= 1'b0;
			ar[p] <= '0;
			arvalid[p] <= 1'b0;
			rready[p] <= 1'b0;
		end
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		for (int p = 0; p < 2; p++) begin
			check_bit({port_name(p), "_awready"}, awready[p], 1'b0);
			check_bit({port_name(p), "_wready"}, wready[p], 1'b0);
			check_bit({port_name(p), "_bvalid"}, bvalid[p], 1'b0);
			check_bit({port_name(p), "_arready"}, arready[p], 1'b0);
			check_bit({port_name(p), "_rvalid"}, rvalid[p], 1'b0);
		end

		// known contents for the whole window first
		st = SEED;
		for (int i = 0; i < WIN_WORDS; i++) begin
			st = lcg_step(st);
			start_write(0, mem_pkg::addr_t'(i * 4), st, 4'hF);
			wait_accept(0, 1'b1);
			wait_response(0, 1'b1, 0);
		end

		fork
			run_master(0, N_OPS);
			run_master(1, N_OPS);
		join
		repeat (2) @(posedge clk);

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/mem_subsystem.sv ====
// imem drives RAM port a and has priority on collisions, dmem drives port b
`default_nettype none
`timescale 1ns/100ps

module mem_subsystem (
	input  wire logic               clk,
	input  wire logic               rst,

	// imem port
	input  wire mem_pkg::axi_aw_t   imem_aw,
	input  wire logic               imem_awvalid,
	output logic                    imem_awready,
	input  wire mem_pkg::axi_w_t    imem_w,
	input  wire logic               imem_wvalid,
	output logic                    imem_wready,
	output mem_pkg::resp_t          imem_b_resp,
	output logic                    imem_bvalid,
	input  wire logic               imem_bready,
	input  wire mem_pkg::axi_ar_t   imem_ar,
	input  wire logic               imem_arvalid,
	output logic                    imem_arready,
	output mem_pkg::axi_r_t         imem_r,
	output logic                    imem_rvalid,
	input  wire logic               imem_rready,

	// dmem port
	input  wire mem_pkg::axi_aw_t   dmem_aw,
	input  wire logic               dmem_awvalid,
	output logic                    dmem_awready,
	input  wire mem_pkg::axi_w_t    dmem_w,
	input  wire logic               dmem_wvalid,
	output logic                    dmem_wready,
	output mem_pkg::resp_t          dmem_b_resp,
	output logic                    dmem_bvalid,
	input  wire logic               dmem_bready,
	input  wire mem_pkg::axi_ar_t   dmem_ar,
	input  wire logic               dmem_arvalid,
	output logic                    dmem_arready,
	output mem_pkg::axi_r_t         dmem_r,
	output logic                    dmem_rvalid,
	input  wire logic               dmem_rready
);

	mem_pkg::ram_req_t ram_req_a;
	mem_pkg::ram_req_t ram_req_b;
	mem_pkg::word_t ram_rddata_a;
	mem_pkg::word_t ram_rddata_b;

	axi_bram_ctrl imem_ctrl_i (
		.clk(clk), .rst(rst),
		.aw(imem_aw), .awvalid(imem_awvalid), .awready(imem_awready),
		.w(imem_w), .wvalid(imem_wvalid), .wready(imem_wready),
		.b_resp(imem_b_resp), .bvalid(imem_bvalid), .bready(imem_bready),
		.ar(imem_ar), .arvalid(imem_arvalid), .arready(imem_arready),
		.r(imem_r), .rvalid(imem_rvalid), .rready(imem_rready),
		.ram_req(ram_req_a), .ram_rddata(ram_rddata_a)
	);

	axi_bram_ctrl dmem_ctrl_i (
		.clk(clk), .rst(rst),
		.aw(dmem_aw), .awvalid(dmem_awvalid), .awready(dmem_awready),
		.w(dmem_w), .wvalid(dmem_wvalid), .wready(dmem_wready),
		.b_resp(dmem_b_resp), .bvalid(dmem_bvalid), .bready(dmem_bready),
		.ar(dmem_ar), .arvalid(dmem_arvalid), .arready(dmem_arready),
		.r(dmem_r), .rvalid(dmem_rvalid), .rready(dmem_rready),
		.ram_req(ram_req_b), .ram_rddata(ram_rddata_b)
	);

	dual_port_ram ram_i (
		.clk(clk),
		.req_a(ram_req_a),
		.rddata_a(ram_rddata_a),
		.req_b(ram_req_b),
		.rddata_b(ram_rddata_b)
	);

endmodule

`default_nettype wire

// ==== src/axi_bram_ctrl.sv ====
// one AXI4-Lite transaction at a time, writes win over reads, no prot fields and no bursts
`default_nettype none
`timescale 1ns/100ps

module axi_bram_ctrl (
	input  wire logic               clk,
	input  wire logic               rst,

	// write address channel
	input  wire mem_pkg::axi_aw_t   aw,
	input  wire logic               awvalid,
	output logic                    awready,

	// write data channel
	input  wire mem_pkg::axi_w_t    w,
	input  wire logic               wvalid,
	output logic                    wready,

	// write response channel
	output mem_pkg::resp_t          b_resp,
	output logic                    bvalid,
	input  wire logic               bready,

	// read address channel
	input  wire mem_pkg::axi_ar_t   ar,
	input  wire logic               arvalid,
	output logic                    arready,

	// read data channel
	output mem_pkg::axi_r_t         r,
	output logic                    rvalid,
	input  wire logic               rready,

	// RAM port
	output mem_pkg::ram_req_t       ram_req,
	input  wire mem_pkg::word_t     ram_rddata
);

	typedef enum logic [1:0] {
		IDLE,
		WRITE_RESP,
		READ_WAIT,
		READ_DATA
	} ctrl_state_t;

	ctrl_state_t state;

	logic wr_req;
	logic wr_hs;
	logic rd_hs;
	logic wr_ok;
	logic rd_ok;

	// error flag of the read in flight
	logic rd_err;

	mem_pkg::ram_addr_t wr_word;
	mem_pkg::ram_addr_t rd_word;

	// address checks
	assign wr_ok = aw.addr < mem_pkg::MEM_BYTES;
	assign rd_ok = ar.addr < mem_pkg::MEM_BYTES;

	assign wr_word = aw.addr[mem_pkg::ADDR_LSB +: mem_pkg::RAM_AW];
	assign rd_word = ar.addr[mem_pkg::ADDR_LSB +: mem_pkg::RAM_AW];

	// aw and w are only taken together
	assign wr_req = awvalid && wvalid;

	assign wr_hs = (state == IDLE) && wr_req;
	assign rd_hs = (state == IDLE) && !wr_req && arvalid;

	assign awready = wr_hs;
	assign wready = wr_hs;
	assign arready = rd_hs;

	assign bvalid = (state == WRITE_RESP);
	assign rvalid = (state == READ_DATA);

	// RAM access happens at the handshake edge
	always_comb begin
		ram_req.en = 1'b0;
		ram_req.we = '0;
		ram_req.addr = rd_word;
		ram_req.wrdata = w.data;

		if (wr_hs) begin
			ram_req.en = wr_ok;
			ram_req.we = wr_ok ? w.strb : '0;
			ram_req.addr = wr_word;
		end else if (rd_hs) begin
			ram_req.en = rd_ok;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			rd_err <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (wr_hs) begin
						state <= WRITE_RESP;
					end else if (rd_hs) begin
						state <= READ_WAIT;
						rd_err <= !rd_ok;
					end
				end

				WRITE_RESP: begin
					if (bready) begin
						state <= IDLE;
					end
				end

				// RAM output is valid during this cycle
				READ_WAIT: begin
					state <= READ_DATA;
				end

				READ_DATA: begin
					if (rready) begin
						state <= IDLE;
					end
				end

				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// response payloads only change when a new one is loaded
	always_ff @(posedge clk) begin
		if (wr_hs) begin
			b_resp <= wr_ok ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
		end

		if (state == READ_WAIT) begin
			if (rd_err) begin
				r.data <= '0;
				r.resp <= mem_pkg::RESP_SLVERR;
			end else begin
				r.data <= ram_rddata;
				r.resp <= mem_pkg::RESP_OKAY;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/dual_port_ram.sv ====
// single clock, read-before-write on both ports, port a wins a same-word write collision
`default_nettype none
`timescale 1ns/100ps

module dual_port_ram (
	input  wire logic               clk,

	input  wire mem_pkg::ram_req_t  req_a,
	output mem_pkg::word_t          rddata_a,

	input  wire mem_pkg::ram_req_t  req_b,
	output mem_pkg::word_t          rddata_b
);

	mem_pkg::word_t mem [mem_pkg::RAM_DEPTH];

	// byte writes, port b first so that port a overrides it
	always_ff @(posedge clk) begin
		for (int i = 0; i < mem_pkg::STRB_W; i++) begin
			if (req_b.en && req_b.we[i]) begin
				mem[req_b.addr][i*mem_pkg::BYTE_W +: mem_pkg::BYTE_W] <=
					req_b.wrdata[i*mem_pkg::BYTE_W +: mem_pkg::BYTE_W];
			end
		end

		for (int i = 0; i < mem_pkg::STRB_W; i++) begin
			if (req_a.en && req_a.we[i]) begin
				mem[req_a.addr][i*mem_pkg::BYTE_W +: mem_pkg::BYTE_W] <=
					req_a.wrdata[i*mem_pkg::BYTE_W +: mem_pkg::BYTE_W];
			end
		end
	end

	// registered reads see the old contents
	always_ff @(posedge clk) begin
		if (req_a.en) begin
			rddata_a <= mem[req_a.addr];
		end
	end

	always_ff @(posedge clk) begin
		if (req_b.en) begin
			rddata_b <= mem[req_b.addr];
		end
	end

endmodule

`default_nettype wire

// ==== src/mem_pkg.sv ====
// byte addresses are 16 bits wide and the RAM covers only the lowest 16 KiB of that space
`default_nettype none

package mem_pkg;

	// bus and RAM widths
	localparam int ADDR_W = 16;
	localparam int DATA_W = 32;
	localparam int BYTE_W = 8;
	localparam int STRB_W = DATA_W / BYTE_W;
	localparam int ADDR_LSB = $clog2(STRB_W);

	// 4096 words of 32 bits
	localparam int RAM_AW = 12;
	localparam int RAM_DEPTH = 1 << RAM_AW;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] word_t;
	typedef logic [STRB_W-1:0] strb_t;
	typedef logic [RAM_AW-1:0] ram_addr_t;
	typedef logic [1:0] resp_t;

	// first byte address past the end of the RAM
	localparam addr_t MEM_BYTES = addr_t'(RAM_DEPTH * STRB_W);

	localparam resp_t RESP_OKAY = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

	typedef struct packed {
		addr_t addr;
	} axi_aw_t;

	typedef struct packed {
		word_t data;
		strb_t strb;
	} axi_w_t;

	typedef struct packed {
		addr_t addr;
	} axi_ar_t;

	typedef struct packed {
		word_t data;
		resp_t resp;
	} axi_r_t;

	// one RAM port request, we holds one bit per byte lane
	typedef struct packed {
		logic en;
		strb_t we;
		ram_addr_t addr;
		word_t wrdata;
	} ram_req_t;

endpackage

`default_nettype wire
